/* dct_pkg.sv */
// ============================
// shared widths, constants and the DCT basis table for the dct_2d
// pipeline. Each file refers to these by scoped name.
// ============================
`default_nettype none

package dct_pkg;

	// ============================
	// widths
	// ============================
	localparam int pix_w  = 8;
	localparam int blk_n  = 8;
	localparam int row_w  = 13;
	localparam int coef_w = 11;

	// output clipping range of a coefficient
	localparam int coef_max = (2 ** (coef_w - 1)) - 1;
	localparam int coef_min = -(2 ** (coef_w - 1));

	// ============================
	// arithmetic
	// ============================
	// basis values are scaled by 2^14, so the two shifts together remove 2^28
	localparam int row_shift = 12;
	localparam int col_shift = 16;

	// the level shift of 128 per pixel only survives in the k=0 basis row
	// because every other row sums to zero. 128 * 8 * 5793
	localparam int dc_offset = 5932032;

	// cycles from the edge sampling a block's last pixel to its first coef_valid
	localparam int dct_latency = 14;

	// C[k][n] at index k*8+n, frequency k outer and sample n inner
	localparam logic signed [15:0] basis [64] = '{
		5793,  5793,  5793,  5793,  5793,  5793,  5793,  5793,
		8035,  6811,  4551,  1598, -1598, -4551, -6811, -8035,
		7568,  3135, -3135, -7568, -7568, -3135,  3135,  7568,
		6811, -1598, -8035, -4551,  4551,  8035,  1598, -6811,
		5793, -5793, -5793,  5793,  5793, -5793, -5793,  5793,
		4551, -8035,  1598,  6811, -6811, -1598,  8035, -4551,
		3135, -7568,  7568, -3135, -3135,  7568, -7568,  3135,
		1598, -4551,  6811, -8035,  8035, -6811,  4551, -1598
	};

endpackage

`default_nettype wire

/* dct_row_stage.sv */
// ============================
// row transform of the 2-D DCT. Takes one pixel per cycle while enable
// is high and emits a full row of 8 rounded values three cycles after
// the edge that samples the row's last pixel
// ============================
`default_nettype none
`timescale 1ns/100ps

module dct_row_stage (
	input  logic                                                 clk,
	input  logic                                                 rst,
	input  logic                                                 enable,
	input  logic [dct_pkg::pix_w-1:0]                            data_in,
	output logic                                                 row_valid,
	output logic [2:0]                                           row_index,
	output logic [dct_pkg::blk_n-1:0][dct_pkg::row_w-1:0]        row_data
);

	logic [2:0] pix_cnt;
	logic [2:0] row_cnt;

	logic [dct_pkg::pix_w-1:0] pix_q;
	logic [2:0] n_q;
	logic [2:0] r_q;
	logic v_q;

	logic signed [31:0] prod [dct_pkg::blk_n];
	logic [2:0] n_p;
	logic [2:0] r_p;
	logic v_p;

	logic signed [31:0] acc [dct_pkg::blk_n];
	logic signed [31:0] rnd [dct_pkg::blk_n];
	logic [2:0] r_a;
	logic last_a;

	// ============================
	// pixel sampling
	// ============================
	always_ff @(posedge clk) begin
		if (rst) begin
			pix_cnt <= '0;
			row_cnt <= '0;
			v_q <= 1'b0;
		end else if (!enable) begin
			// the partial block is dropped and the next one starts at row 0
			pix_cnt <= '0;
			row_cnt <= '0;
			v_q <= 1'b0;
		end else begin
			pix_cnt <= pix_cnt + 3'd1;
			if (pix_cnt == 3'd7)
				row_cnt <= row_cnt + 3'd1;
			v_q <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		pix_q <= data_in;
		n_q <= pix_cnt;
		r_q <= row_cnt;
	end

	// ============================
	// multiply and accumulate
	// ============================
	always_ff @(posedge clk) begin
		if (rst) begin
			v_p <= 1'b0;
			last_a <= 1'b0;
		end else begin
			v_p <= v_q;
			last_a <= v_p && (n_p == 3'd7);
		end
	end

	always_ff @(posedge clk) begin
		n_p <= n_q;
		r_p <= r_q;
		for (int k = 0; k < dct_pkg::blk_n; k++)
			prod[k] <= int'($signed({1'b0, pix_q})) * int'(dct_pkg::basis[{3'(k), n_q}]);
	end

	// each accumulator restarts on the first pixel of a row
	always_ff @(posedge clk) begin
		r_a <= r_p;
		if (v_p) begin
			for (int k = 0; k < dct_pkg::blk_n; k++)
				acc[k] <= ((n_p == 3'd0) ? 32'sd0 : acc[k]) + prod[k];
		end
	end

	// level shift on the DC term only, then round half up
	always_comb begin
		for (int k = 0; k < dct_pkg::blk_n; k++) begin
			if (k == 0)
				rnd[k] = (acc[k] - dct_pkg::dc_offset + (1 <<< (dct_pkg::row_shift - 1)))
					>>> dct_pkg::row_shift;
			else
				rnd[k] = (acc[k] + (1 <<< (dct_pkg::row_shift - 1))) >>> dct_pkg::row_shift;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			row_valid <= 1'b0;
		else
			row_valid <= last_a;
	end

	always_ff @(posedge clk) begin
		if (last_a) begin
			row_index <= r_a;
			for (int k = 0; k < dct_pkg::blk_n; k++)
				row_data[k] <= rnd[k][dct_pkg::row_w-1:0];
		end
	end

endmodule

`default_nettype wire

/* dct_transpose_buffer.sv */
// ============================
// transpose buffer between the two DCT stages. Rows are written whole
// into the fill bank and a full bank is replayed one value per cycle
// in column order
// ============================
`default_nettype none
`timescale 1ns/100ps

module dct_transpose_buffer (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          row_valid,
	input  logic [2:0]                                    row_index,
	input  logic [dct_pkg::blk_n-1:0][dct_pkg::row_w-1:0] row_data,
	output logic                                          col_valid,
	output logic [dct_pkg::row_w-1:0]                     col_data
);

	// word address is row*8 + column
	logic [dct_pkg::row_w-1:0] mem [2][64];

	logic [1:0] full;
	logic fill_bank;
	logic rd_bank;
	logic rd_active;
	logic [5:0] rd_cnt;

	// ============================
	// write side
	// ============================
	always_ff @(posedge clk) begin
		if (row_valid) begin
			for (int k = 0; k < dct_pkg::blk_n; k++)
				mem[fill_bank][{row_index, 3'(k)}] <= row_data[k];
		end
	end

	// ============================
	// bank control and replay
	// ============================
	always_ff @(posedge clk) begin
		if (rst) begin
			full <= '0;
			fill_bank <= 1'b0;
			rd_bank <= 1'b0;
			rd_active <= 1'b0;
			rd_cnt <= '0;
		end else begin
			if (rd_active) begin
				rd_cnt <= rd_cnt + 6'd1;
				if (rd_cnt == 6'd63) begin
					// release this bank and go straight on if the other is ready
					full[rd_bank] <= 1'b0;
					rd_bank <= ~rd_bank;
					rd_active <= full[~rd_bank];
				end
			end else if (full[rd_bank]) begin
				rd_active <= 1'b1;
				rd_cnt <= '0;
			end

			// row 7 completes the bank
			if (row_valid && (row_index == 3'd7)) begin
				full[fill_bank] <= 1'b1;
				fill_bank <= ~fill_bank;
			end
		end
	end

	// row n inner, column v outer
	assign col_valid = rd_active;
	assign col_data = mem[rd_bank][{rd_cnt[2:0], rd_cnt[5:3]}];

endmodule

`default_nettype wire

/* dct_col_stage.sv */
// ============================
// column transform of the 2-D DCT. Accumulates 8 frequencies over each
// replayed column, then rounds, clips and shifts the 8 coefficients out
// one per cycle while the next column accumulates
// ============================
`default_nettype none
`timescale 1ns/100ps

module dct_col_stage (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        col_valid,
	input  logic [dct_pkg::row_w-1:0]   col_data,
	output logic [dct_pkg::coef_w-1:0]  coef,
	output logic                        coef_valid
);

	logic [2:0] n;
	logic col_done;

	logic signed [31:0] acc [dct_pkg::blk_n];
	logic signed [31:0] rnd [dct_pkg::blk_n];
	logic signed [31:0] clip [dct_pkg::blk_n];

	logic [dct_pkg::coef_w-1:0] sr [dct_pkg::blk_n];
	logic [dct_pkg::blk_n-1:0] sr_v;

	// ============================
	// accumulation
	// ============================
	always_ff @(posedge clk) begin
		if (rst) begin
			n <= '0;
			col_done <= 1'b0;
		end else begin
			col_done <= col_valid && (n == 3'd7);
			if (col_valid)
				n <= n + 3'd1;
			else
				n <= '0;
		end
	end

	// the first element of a column overwrites the previous sum
	always_ff @(posedge clk) begin
		if (col_valid) begin
			for (int u = 0; u < dct_pkg::blk_n; u++)
				acc[u] <= ((n == 3'd0) ? 32'sd0 : acc[u])
					+ int'($signed(col_data)) * int'(dct_pkg::basis[{3'(u), n}]);
		end
	end

	// ============================
	// rounding and clipping
	// ============================
	always_comb begin
		for (int u = 0; u < dct_pkg::blk_n; u++) begin
			rnd[u] = (acc[u] + (1 <<< (dct_pkg::col_shift - 1))) >>> dct_pkg::col_shift;
			if (rnd[u] > dct_pkg::coef_max)
				clip[u] = dct_pkg::coef_max;
			else if (rnd[u] < dct_pkg::coef_min)
				clip[u] = dct_pkg::coef_min;
			else
				clip[u] = rnd[u];
		end
	end

	// ============================
	// serial output
	// ============================
	always_ff @(posedge clk) begin
		if (rst)
			sr_v <= '0;
		else if (col_done)
			sr_v <= '1;
		else
			sr_v <= sr_v >> 1;
	end

	// u = 0 leaves first
	always_ff @(posedge clk) begin
		if (col_done) begin
			for (int u = 0; u < dct_pkg::blk_n; u++)
				sr[u] <= clip[u][dct_pkg::coef_w-1:0];
		end else begin
			for (int u = 0; u < dct_pkg::blk_n - 1; u++)
				sr[u] <= sr[u + 1];
		end
	end

	assign coef = sr[0];
	assign coef_valid = sr_v[0];

endmodule

`default_nettype wire

/* dct_2d.sv */
// ============================
// 8x8 forward DCT for the luma path. Pixels go in row-major while
// enable is high and coefficients come out serially on coef
// ============================
`default_nettype none
`timescale 1ns/100ps

module dct_2d (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        enable,
	input  logic [dct_pkg::pix_w-1:0]   data_in,
	output logic [dct_pkg::coef_w-1:0]  coef,
	output logic                        coef_valid
);

	logic                                          row_valid;
	logic [2:0]                                    row_index;
	logic [dct_pkg::blk_n-1:0][dct_pkg::row_w-1:0] row_data;
	logic                                          col_valid;
	logic [dct_pkg::row_w-1:0]                     col_data;

	dct_row_stage u_row (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.data_in   (data_in),
		.row_valid (row_valid),
		.row_index (row_index),
		.row_data  (row_data)
	);

	dct_transpose_buffer u_buf (
		.clk       (clk),
		.rst       (rst),
		.row_valid (row_valid),
		.row_index (row_index),
		.row_data  (row_data),
		.col_valid (col_valid),
		.col_data  (col_data)
	);

	dct_col_stage u_col (
		.clk        (clk),
		.rst        (rst),
		.col_valid  (col_valid),
		.col_data   (col_data),
		.coef       (coef),
		.coef_valid (coef_valid)
	);

endmodule

`default_nettype wire

/* dct_2d_checker.sv */
// ============================
// assertions on the DCT top level and its transpose buffer, bound
// into dct_2d by the testbench
// ============================
`default_nettype none
`timescale 1ns/100ps

module dct_2d_checker (
	input logic                       clk,
	input logic                       rst,
	input logic [dct_pkg::coef_w-1:0] coef,
	input logic                       coef_valid,
	input logic                       row_valid,
	input logic                       rd_active,
	input logic                       rd_bank,
	input logic                       fill_bank
);

	int assert_fails = 0;
	logic [5:0] run_len;

	// wraps every 64, so a whole number of blocks leaves it at zero
	always_ff @(posedge clk) begin
		if (rst || !coef_valid)
			run_len <= '0;
		else
			run_len <= run_len + 6'd1;
	end

	a_reset_quiet: assert property (@(posedge clk) rst |=> !coef_valid)
		else begin
			assert_fails++;
			$error("coef_valid high right after a reset edge");
		end

	a_whole_blocks: assert property (@(posedge clk) disable iff (rst)
		$fell(coef_valid) |-> run_len == 6'd0)
		else begin
			assert_fails++;
			$error("coef_valid run is not a multiple of 64");
		end

	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		row_valid |-> !(rd_active && (rd_bank == fill_bank)))
		else begin
			assert_fails++;
			$error("row written into the bank under replay");
		end

	a_coef_known: assert property (@(posedge clk) disable iff (rst)
		coef_valid |-> !$isunknown(coef))
		else begin
			assert_fails++;
			$error("coef has unknown bits while valid");
		end

endmodule

`default_nettype wire

/* dct_2d_tb.sv */
// ============================
// testbench for the 8x8 DCT. Streams a table of blocks through the DUT
// and compares every coefficient with an integer model of the transform
// ============================
`default_nettype none
`timescale 1ns/100ps

module dct_2d_tb;

	localparam logic [1:0] kind_flat    = 2'd0;
	localparam logic [1:0] kind_ramp    = 2'd1;
	localparam logic [1:0] kind_random  = 2'd2;
	localparam logic [1:0] kind_checker = 2'd3;

	localparam logic [1:0] flag_none  = 2'd0;
	localparam logic [1:0] flag_gap   = 2'd1;
	localparam logic [1:0] flag_abort = 2'd2;

	localparam int n_entries = 10;
	localparam int abort_len = 37;
	localparam int gap_len = 5;
	localparam int cycle_limit = n_entries * 64 + dct_pkg::dct_latency + 200;

	typedef struct packed {
		logic [1:0]         kind;
		logic [7:0]         value;
		logic [1:0]         flag;
		logic signed [11:0] exp_dc;
	} entry_t;

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       enable;
	logic [dct_pkg::pix_w-1:0]  data_in;
	logic [dct_pkg::coef_w-1:0] coef;
	logic                       coef_valid;

	entry_t stim [n_entries];
	int pix [64];
	int exp_q [$];
	int start_q [$];
	int cyc = 0;
	int coef_idx = 0;
	int exp_val;
	int exp_start;

	dct_2d i_dut (
		.clk        (clk),
		.rst        (rst),
		.enable     (enable),
		.data_in    (data_in),
		.coef       (coef),
		.coef_valid (coef_valid)
	);

	bind dct_2d dct_2d_checker u_chk (
		.clk        (clk),
		.rst        (rst),
		.coef       (coef),
		.coef_valid (coef_valid),
		.row_valid  (row_valid),
		.rd_active  (u_buf.rd_active),
		.rd_bank    (u_buf.rd_bank),
		.fill_bank  (u_buf.fill_bank)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	always @(posedge clk) begin
		if (cyc >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic signed [31:0] got,
			input logic signed [31:0] expected);
		if (got !== expected) begin
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, expected);
			$display("Regression failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// ============================
	// stimulus table
	// ============================
	task automatic load_table();
		stim[0] = '{kind_flat,    8'd128, flag_none,  12'sd0};
		stim[1] = '{kind_flat,    8'd255, flag_none,  12'sd1016};
		stim[2] = '{kind_ramp,    8'd0,   flag_none,  12'sd0};
		stim[3] = '{kind_checker, 8'd255, flag_gap,   12'sd0};
		stim[4] = '{kind_random,  8'd0,   flag_abort, 12'sd0};
		stim[5] = '{kind_random,  8'd0,   flag_none,  12'sd0};
		stim[6] = '{kind_flat,    8'd0,   flag_none,  -12'sd1024};
		stim[7] = '{kind_ramp,    8'd200, flag_gap,   12'sd0};
		stim[8] = '{kind_checker, 8'd40,  flag_abort, 12'sd0};
		stim[9] = '{kind_random,  8'd0,   flag_none,  12'sd0};
	endtask

	task automatic make_pixels(input logic [1:0] kind, input int value);
		for (int i = 0; i < 64; i++) begin
			case (kind)
				kind_flat:    pix[i] = value;
				kind_ramp:    pix[i] = (value + 4 * i) & 255;
				kind_random:  pix[i] = $urandom & 255;
				default:      pix[i] = (((i / 8) + (i % 8)) & 1) ? value : 255 - value;
			endcase
		end
	endtask

	// integer 2-D DCT, row pass then column pass, coefficients in v outer, u inner order
	task automatic model_block(input logic [1:0] kind, input int exp_dc);
		int rowv [8][8];
		int s;
		int t;
		logic signed [12:0] r13;
		for (int r = 0; r < 8; r++) begin
			for (int k = 0; k < 8; k++) begin
				s = 0;
				for (int n = 0; n < 8; n++)
					s += pix[r * 8 + n] * int'(dct_pkg::basis[k * 8 + n]);
				if (k == 0)
					s -= dct_pkg::dc_offset;
				t = (s + (1 << (dct_pkg::row_shift - 1))) >>> dct_pkg::row_shift;
				r13 = t[12:0];
				rowv[r][k] = int'(r13);
			end
		end
		for (int v = 0; v < 8; v++) begin
			for (int u = 0; u < 8; u++) begin
				s = 0;
				for (int n = 0; n < 8; n++)
					s += rowv[n][v] * int'(dct_pkg::basis[u * 8 + n]);
				t = (s + (1 << (dct_pkg::col_shift - 1))) >>> dct_pkg::col_shift;
				if (t > 1023)
					t = 1023;
				else if (t < -1024)
					t = -1024;
				// a flat block has only a DC term of 8 * (v - 128)
				if (kind == kind_flat)
					check_value("model coefficient of a flat block", t,
						(u == 0 && v == 0) ? exp_dc : 0);
				exp_q.push_back(t);
			end
		end
	endtask

	task automatic stream_block(input logic [1:0] flag);
		int len;
		len = (flag == flag_abort) ? abort_len : 64;
		for (int i = 0; i < len; i++) begin
			@(posedge clk);
			enable <= 1'b1;
			data_in <= 8'(pix[i]);
			// sampled on the next edge and seen by the monitor one edge after coef_valid rises
			if (i == 63)
				start_q.push_back(cyc + 2 + dct_pkg::dct_latency);
		end
		if (flag != flag_none) begin
			for (int i = 0; i < gap_len; i++) begin
				@(posedge clk);
				enable <= 1'b0;
				data_in <= '0;
			end
		end
	endtask

	// ============================
	// output monitor
	// ============================
	always @(posedge clk) begin
		if (i_dut.u_chk.assert_fails != 0)
			stop_with_failure("a checker assertion fired");
		if (!rst && coef_valid) begin
			if (coef_idx == 0) begin
				if (start_q.size() == 0)
					stop_with_failure("coefficients appeared with no complete block pending");
				else begin
					exp_start = start_q.pop_front();
					check_value("cycle of the first coefficient", cyc, exp_start);
				end
			end
			if (exp_q.size() == 0)
				stop_with_failure("more coefficients came out than were expected");
			else begin
				exp_val = exp_q.pop_front();
				check_value($sformatf("coefficient %0d of the block", coef_idx),
					$signed(coef), exp_val);
			end
			coef_idx = (coef_idx + 1) % 64;
		end
	end

	initial begin
		void'($urandom(32'hbfbe_4232));
		rst = 1'b1;
		enable = 1'b0;
		data_in = '0;
		load_table();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);
		for (int e = 0; e < n_entries; e++) begin
			make_pixels(stim[e].kind, int'(stim[e].value));
			if (stim[e].flag != flag_abort)
				model_block(stim[e].kind, int'(stim[e].exp_dc));
			stream_block(stim[e].flag);
		end
		@(posedge clk);
		enable <= 1'b0;
		data_in <= '0;
		while (exp_q.size() != 0 || start_q.size() != 0)
			@(posedge clk);
		// a few idle cycles to catch stray coefficients
		repeat (20) @(posedge clk);
		if (i_dut.u_chk.assert_fails != 0) begin
			$display("a checker assertion fired during the run");
			$display("Regression failed");
			$fatal(1, "assertion failure");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* dct_2d.f */
dct_pkg.sv
dct_row_stage.sv
dct_transpose_buffer.sv
dct_col_stage.sv
dct_2d.sv
dct_2d_checker.sv
dct_2d_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dct_2d_tb
FILELIST  ?= dct_2d.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed
FAIL_MSG  ?= Regression failed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
